//--- hw/cache_pkg.sv
package cache_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int s_offset = 5;
	localparam int s_index = 3;
	localparam int s_tag = 24;
	localparam int num_sets = 8;
	localparam int num_ways = 2;
	localparam int line_bytes = 32;

	typedef logic [31:0] addr_t;
	typedef logic [8*line_bytes-1:0] line_t;
	typedef logic [line_bytes-1:0] byte_mask_t;
	typedef logic [s_tag-1:0] tag_t;
	typedef logic [s_index-1:0] index_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control encodings
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [2:0] {
		idle,
		compare,
		write_back,
		allocate,
		reread
	} cache_state_t;

	// address driven to physical memory
	typedef enum logic {
		request_addr,
		victim_addr
	} pmem_addr_sel_t;

	// where a way's new line data comes from
	typedef enum logic {
		from_pmem,
		from_cpu
	} line_src_t;

endpackage

//--- hw/line_array.sv
`timescale 1ns/1ps

module line_array (
	input logic clk,
	input logic rst_n,
	input cache_pkg::byte_mask_t write_en,
	input cache_pkg::index_t rindex,
	input cache_pkg::index_t windex,
	input cache_pkg::line_t datain,
	output cache_pkg::line_t dataout
);

	cache_pkg::line_t lines [cache_pkg::num_sets];

	// byte lanes written independently, read returns the old line on a collision
	always_ff @(posedge clk) begin
		for (int b = 0; b < cache_pkg::line_bytes; b++) begin
			if (write_en[b]) begin
				lines[windex][8*b +: 8] <= datain[8*b +: 8];
			end
		end
		dataout <= lines[rindex];
	end

	// a write must never land on an unknown set
	windex_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		(|write_en) |-> !$isunknown(windex)
	);

endmodule

//--- hw/meta_array.sv
`timescale 1ns/1ps

module meta_array #(
	parameter int width = 1
) (
	input logic clk,
	input logic rst_n,
	input logic load,
	input cache_pkg::index_t rindex,
	input cache_pkg::index_t windex,
	input logic [width-1:0] datain,
	output logic [width-1:0] dataout
);

	logic [width-1:0] entries [cache_pkg::num_sets];

	// every entry starts at zero, so flags come up invalid and clean
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < cache_pkg::num_sets; i++) begin
				entries[i] <= '0;
			end
			dataout <= '0;
		end else begin
			if (load) begin
				entries[windex] <= datain;
			end
			dataout <= entries[rindex];
		end
	end

endmodule

//--- hw/cache_datapath.sv
`timescale 1ns/1ps

module cache_datapath (
	input logic clk,
	input logic rst_n,
	input cache_pkg::addr_t mem_address,
	input cache_pkg::line_t mem_wdata256,
	input cache_pkg::byte_mask_t mem_byte_enable256,
	input cache_pkg::line_t pmem_rdata,
	input logic load_pipeline,
	input logic [1:0] load_tag,
	input logic [1:0] load_data,
	input cache_pkg::line_src_t data_src,
	input logic [1:0] set_valid,
	input logic [1:0] set_dirty,
	input logic [1:0] clear_dirty,
	input logic load_lru,
	input cache_pkg::pmem_addr_sel_t pmem_addr_sel,
	output cache_pkg::line_t mem_rdata256,
	output cache_pkg::line_t pmem_wdata,
	output cache_pkg::addr_t pmem_address,
	output logic hit,
	output logic hit_way,
	output logic victim_dirty,
	output logic victim_way
);

	cache_pkg::index_t live_index;
	cache_pkg::addr_t req_addr;
	cache_pkg::line_t req_wdata;
	cache_pkg::byte_mask_t req_mask;
	cache_pkg::tag_t req_tag;
	cache_pkg::index_t req_index;

	cache_pkg::line_t line_in;
	cache_pkg::byte_mask_t write_en [cache_pkg::num_ways];
	cache_pkg::line_t data_out [cache_pkg::num_ways];
	cache_pkg::tag_t tag_out [cache_pkg::num_ways];
	logic [1:0] valid_out;
	logic [1:0] dirty_out;
	logic [1:0] load_dirty;
	logic [1:0] way_hit;
	logic lru_out;
	logic lru_in;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 1: arrays read with the live index
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign live_index = mem_address[cache_pkg::s_offset +: cache_pkg::s_index];

	// request held for the compare stage and all array writes
	always_ff @(posedge clk) begin
		if (load_pipeline) begin
			req_addr <= mem_address;
			req_wdata <= mem_wdata256;
			req_mask <= mem_byte_enable256;
		end
	end

	assign req_index = req_addr[cache_pkg::s_offset +: cache_pkg::s_index];
	assign req_tag = req_addr[cache_pkg::s_offset + cache_pkg::s_index +: cache_pkg::s_tag];

	assign line_in = (data_src == cache_pkg::from_pmem) ? pmem_rdata : req_wdata;

	for (genvar w = 0; w < cache_pkg::num_ways; w++) begin : g_way
		// refill writes the whole line, a cpu write only its masked bytes
		always_comb begin
			if (!load_data[w]) begin
				write_en[w] = '0;
			end else if (data_src == cache_pkg::from_pmem) begin
				write_en[w] = '1;
			end else begin
				write_en[w] = req_mask;
			end
		end

		assign load_dirty[w] = set_dirty[w] | clear_dirty[w];

		line_array u_data (
			.clk(clk),
			.rst_n(rst_n),
			.write_en(write_en[w]),
			.rindex(live_index),
			.windex(req_index),
			.datain(line_in),
			.dataout(data_out[w])
		);

		meta_array #(.width(cache_pkg::s_tag)) u_tag (
			.clk(clk),
			.rst_n(rst_n),
			.load(load_tag[w]),
			.rindex(live_index),
			.windex(req_index),
			.datain(req_tag),
			.dataout(tag_out[w])
		);

		meta_array #(.width(1)) u_valid (
			.clk(clk),
			.rst_n(rst_n),
			.load(set_valid[w]),
			.rindex(live_index),
			.windex(req_index),
			.datain(1'b1),
			.dataout(valid_out[w])
		);

		// set wins the data value, clear writes a zero
		meta_array #(.width(1)) u_dirty (
			.clk(clk),
			.rst_n(rst_n),
			.load(load_dirty[w]),
			.rindex(live_index),
			.windex(req_index),
			.datain(set_dirty[w]),
			.dataout(dirty_out[w])
		);

		assign way_hit[w] = valid_out[w] && (tag_out[w] == req_tag);
	end

	meta_array #(.width(1)) u_lru (
		.clk(clk),
		.rst_n(rst_n),
		.load(load_lru),
		.rindex(live_index),
		.windex(req_index),
		.datain(lru_in),
		.dataout(lru_out)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 2: compare and output muxes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign hit = |way_hit;
	assign hit_way = way_hit[1];

	// lru bit names the way to replace next
	assign lru_in = ~hit_way;
	assign victim_way = lru_out;
	assign victim_dirty = valid_out[victim_way] & dirty_out[victim_way];

	assign mem_rdata256 = data_out[hit_way];
	assign pmem_wdata = data_out[victim_way];

	always_comb begin
		if (pmem_addr_sel == cache_pkg::victim_addr) begin
			pmem_address = {tag_out[victim_way], req_index, {cache_pkg::s_offset{1'b0}}};
		end else begin
			pmem_address = {req_tag, req_index, {cache_pkg::s_offset{1'b0}}};
		end
	end

	// a line is only ever filled into the way that missed
	one_way_hit: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(&way_hit)
	);

endmodule

//--- hw/cache_control.sv
`timescale 1ns/1ps

module cache_control (
	input logic clk,
	input logic rst_n,
	input logic mem_read,
	input logic mem_write,
	input logic hit,
	input logic hit_way,
	input logic victim_dirty,
	input logic victim_way,
	input logic pmem_resp,
	output logic mem_resp,
	output logic pmem_read,
	output logic pmem_write,
	output logic load_pipeline,
	output logic load_lru,
	output logic [1:0] load_tag,
	output logic [1:0] load_data,
	output logic [1:0] set_valid,
	output logic [1:0] set_dirty,
	output logic [1:0] clear_dirty,
	output cache_pkg::line_src_t data_src,
	output cache_pkg::pmem_addr_sel_t pmem_addr_sel
);

	cache_pkg::cache_state_t state;
	cache_pkg::cache_state_t next_state;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= cache_pkg::idle;
		end else begin
			state <= next_state;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// next state and command decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		next_state = state;
		mem_resp = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		load_pipeline = 1'b0;
		load_lru = 1'b0;
		load_tag = '0;
		load_data = '0;
		set_valid = '0;
		set_dirty = '0;
		clear_dirty = '0;
		data_src = cache_pkg::from_pmem;
		pmem_addr_sel = cache_pkg::request_addr;

		unique case (state)
			cache_pkg::idle: begin
				if (mem_read || mem_write) begin
					load_pipeline = 1'b1;
					next_state = cache_pkg::compare;
				end
			end

			cache_pkg::compare: begin
				if (hit) begin
					mem_resp = 1'b1;
					load_lru = 1'b1;
					if (mem_write) begin
						data_src = cache_pkg::from_cpu;
						load_data[hit_way] = 1'b1;
						set_dirty[hit_way] = 1'b1;
					end
					next_state = cache_pkg::idle;
				end else if (victim_dirty) begin
					next_state = cache_pkg::write_back;
				end else begin
					next_state = cache_pkg::allocate;
				end
			end

			// victim line goes out before the refill overwrites it
			cache_pkg::write_back: begin
				pmem_write = 1'b1;
				pmem_addr_sel = cache_pkg::victim_addr;
				if (pmem_resp) begin
					next_state = cache_pkg::allocate;
				end
			end

			cache_pkg::allocate: begin
				pmem_read = 1'b1;
				if (pmem_resp) begin
					load_data[victim_way] = 1'b1;
					load_tag[victim_way] = 1'b1;
					set_valid[victim_way] = 1'b1;
					clear_dirty[victim_way] = 1'b1;
					next_state = cache_pkg::reread;
				end
			end

			// arrays need one cycle to present the filled line
			cache_pkg::reread: begin
				next_state = cache_pkg::compare;
			end

			default: begin
				next_state = cache_pkg::idle;
			end
		endcase
	end

	// a response only answers a request that is still held
	resp_only_in_compare: assert property (
		@(posedge clk) disable iff (!rst_n)
		mem_resp |-> (state == cache_pkg::compare) && (mem_read || mem_write)
	);

	pmem_one_direction: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(pmem_read && pmem_write)
	);

endmodule

//--- hw/cache.sv
`timescale 1ns/1ps

module cache (
	input logic clk,
	input logic rst_n,
	// processor side
	input logic mem_read,
	input logic mem_write,
	input cache_pkg::addr_t mem_address,
	input cache_pkg::line_t mem_wdata256,
	input cache_pkg::byte_mask_t mem_byte_enable256,
	output cache_pkg::line_t mem_rdata256,
	output logic mem_resp,
	// physical memory side
	output logic pmem_read,
	output logic pmem_write,
	output cache_pkg::addr_t pmem_address,
	output cache_pkg::line_t pmem_wdata,
	input cache_pkg::line_t pmem_rdata,
	input logic pmem_resp
);

	logic hit;
	logic hit_way;
	logic victim_dirty;
	logic victim_way;
	logic load_pipeline;
	logic load_lru;
	logic [1:0] load_tag;
	logic [1:0] load_data;
	logic [1:0] set_valid;
	logic [1:0] set_dirty;
	logic [1:0] clear_dirty;
	cache_pkg::line_src_t data_src;
	cache_pkg::pmem_addr_sel_t pmem_addr_sel;

	cache_control u_control (
		.clk(clk),
		.rst_n(rst_n),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.hit(hit),
		.hit_way(hit_way),
		.victim_dirty(victim_dirty),
		.victim_way(victim_way),
		.pmem_resp(pmem_resp),
		.mem_resp(mem_resp),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.load_pipeline(load_pipeline),
		.load_lru(load_lru),
		.load_tag(load_tag),
		.load_data(load_data),
		.set_valid(set_valid),
		.set_dirty(set_dirty),
		.clear_dirty(clear_dirty),
		.data_src(data_src),
		.pmem_addr_sel(pmem_addr_sel)
	);

	cache_datapath u_datapath (
		.clk(clk),
		.rst_n(rst_n),
		.mem_address(mem_address),
		.mem_wdata256(mem_wdata256),
		.mem_byte_enable256(mem_byte_enable256),
		.pmem_rdata(pmem_rdata),
		.load_pipeline(load_pipeline),
		.load_tag(load_tag),
		.load_data(load_data),
		.data_src(data_src),
		.set_valid(set_valid),
		.set_dirty(set_dirty),
		.clear_dirty(clear_dirty),
		.load_lru(load_lru),
		.pmem_addr_sel(pmem_addr_sel),
		.mem_rdata256(mem_rdata256),
		.pmem_wdata(pmem_wdata),
		.pmem_address(pmem_address),
		.hit(hit),
		.hit_way(hit_way),
		.victim_dirty(victim_dirty),
		.victim_way(victim_way)
	);

endmodule

//--- tb/cache_tb_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shadow memory and physical memory image
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// slot is {tag[2:0], set}, all tags in use stay below 8
cache_pkg::line_t shadow_mem [64];
cache_pkg::line_t phys_mem [64];
int pmem_reads;
int pmem_writes;
int resp_errors;
cache_pkg::addr_t last_wb_addr;
cache_pkg::line_t last_wb_data;

function automatic int line_slot(input cache_pkg::addr_t addr);
	return int'(addr[10:5]);
endfunction

function automatic cache_pkg::addr_t line_addr(input int tag, input int set);
	return cache_pkg::addr_t'((tag << 8) | (set << 5));
endfunction

function automatic cache_pkg::line_t random_line();
	cache_pkg::line_t value;
	for (int w = 0; w < 8; w++) begin
		value[32*w +: 32] = $urandom();
	end
	return value;
endfunction

// line expected after an access, write bytes merged under the mask
function automatic cache_pkg::line_t expected_line(
	input cache_pkg::addr_t addr,
	input logic is_write,
	input cache_pkg::line_t wdata,
	input cache_pkg::byte_mask_t mask
);
	cache_pkg::line_t result;
	result = shadow_mem[line_slot(addr)];
	if (is_write) begin
		for (int b = 0; b < cache_pkg::line_bytes; b++) begin
			if (mask[b]) begin
				result[8*b +: 8] = wdata[8*b +: 8];
			end
		end
	end
	return result;
endfunction

// physical memory, one request at a time after 1 to 6 cycles
initial begin
	int latency;
	int slot;
	pmem_resp = 1'b0;
	pmem_rdata = '0;
	pmem_reads = 0;
	pmem_writes = 0;
	resp_errors = 0;
	wait (rst_n === 1'b1);
	// memory image is the shadow as preloaded
	for (int s = 0; s < 64; s++) begin
		phys_mem[s] = shadow_mem[s];
	end
	forever begin
		@(negedge clk);
		pmem_resp = 1'b0;
		if (pmem_read || pmem_write) begin
			latency = $urandom_range(6, 1);
			repeat (latency - 1) @(negedge clk);
			slot = line_slot(pmem_address);
			assert (pmem_address[31:11] == '0 && pmem_address[4:0] == '0) else begin
				$display("Error at %0t ns: pmem request to %h lies outside the preloaded lines",
					$time, pmem_address);
				resp_errors++;
			end
			if (pmem_write) begin
				phys_mem[slot] = pmem_wdata;
				last_wb_addr = pmem_address;
				last_wb_data = pmem_wdata;
				pmem_writes++;
			end else begin
				pmem_rdata = phys_mem[slot];
				pmem_reads++;
			end
			pmem_resp = 1'b1;
		end
	end
end

//--- tb/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;

	localparam int max_requests = 300;
	localparam int worst_miss_cycles = 24;
	localparam int timeout_cycles = 2 * max_requests * worst_miss_cycles;

	logic clk = 1'b0;
	logic rst_n;
	logic mem_read;
	logic mem_write;
	cache_pkg::addr_t mem_address;
	cache_pkg::line_t mem_wdata256;
	cache_pkg::byte_mask_t mem_byte_enable256;
	cache_pkg::line_t mem_rdata256;
	logic mem_resp;
	logic pmem_read;
	logic pmem_write;
	cache_pkg::addr_t pmem_address;
	cache_pkg::line_t pmem_wdata;
	cache_pkg::line_t pmem_rdata;
	logic pmem_resp;

	int stim_errors;
	int check_errors;
	int data_checks;
	int tests_failed;
	int test_errors_start;
	int reads_start;
	int writes_start;
	int cycle_count;
	logic cur_is_write;
	cache_pkg::line_t exp_line;
	bit touched [64];

	`include "cache_tb_model.svh"

	cache UUT (
		.clk(clk),
		.rst_n(rst_n),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_address(mem_address),
		.mem_wdata256(mem_wdata256),
		.mem_byte_enable256(mem_byte_enable256),
		.mem_rdata256(mem_rdata256),
		.mem_resp(mem_resp),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata),
		.pmem_rdata(pmem_rdata),
		.pmem_resp(pmem_resp)
	);

	always #4 clk = ~clk;

	// read responses checked against the shadow
	always @(negedge clk) begin
		if (rst_n && mem_resp && !cur_is_write) begin
			data_checks++;
			assert (mem_rdata256 == exp_line) else begin
				$display("Error at %0t ns: mem_rdata256 expected %h got %h",
					$time, exp_line, mem_rdata256);
				check_errors++;
			end
		end
	end

	function automatic int total_errors();
		return stim_errors + check_errors + resp_errors;
	endfunction

	// one request held until mem_resp, dropped in the following cycle
	task automatic access(input cache_pkg::addr_t addr, input logic is_write,
		input cache_pkg::line_t wdata, input cache_pkg::byte_mask_t mask);
		@(negedge clk);
		exp_line = expected_line(addr, is_write, wdata, mask);
		cur_is_write = is_write;
		mem_address = addr;
		mem_wdata256 = wdata;
		mem_byte_enable256 = mask;
		mem_read = !is_write;
		mem_write = is_write;
		do begin
			@(negedge clk);
		end while (!mem_resp);
		@(posedge clk);
		if (is_write) begin
			shadow_mem[line_slot(addr)] = exp_line;
		end
		touched[line_slot(addr)] = 1'b1;
		@(negedge clk);
		mem_read = 1'b0;
		mem_write = 1'b0;
	endtask

	task automatic read_line(input int tag, input int set);
		access(line_addr(tag, set), 1'b0, '0, '0);
	endtask

	task automatic write_line(input int tag, input int set);
		access(line_addr(tag, set), 1'b1, random_line(), cache_pkg::byte_mask_t'($urandom()));
	endtask

	task automatic snapshot_traffic();
		reads_start = pmem_reads;
		writes_start = pmem_writes;
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		assert (actual == expected) else begin
			$display("Error at %0t ns: %s expected %0d got %0d", $time, name, expected, actual);
			stim_errors++;
		end
	endtask

	task automatic finish_test(input int num, input string name);
		if (total_errors() == test_errors_start) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			$display("test %0d %s: %0d errors", num, name, total_errors() - test_errors_start);
			tests_failed++;
		end
		test_errors_start = total_errors();
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < timeout_cycles) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", timeout_cycles);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		int tag;
		int set;
		void'($urandom(32'h8d9f_da83));
		rst_n = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_address = '0;
		mem_wdata256 = '0;
		mem_byte_enable256 = '0;
		stim_errors = 0;
		check_errors = 0;
		data_checks = 0;
		tests_failed = 0;
		test_errors_start = 0;
		cur_is_write = 1'b0;
		exp_line = '0;
		for (int s = 0; s < 64; s++) begin
			shadow_mem[s] = random_line();
			touched[s] = 1'b0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		snapshot_traffic();
		read_line(1, 0);
		check_count("pmem_read count", 1, pmem_reads - reads_start);
		check_count("pmem_write count", 0, pmem_writes - writes_start);
		finish_test(1, "cold read miss");

		snapshot_traffic();
		read_line(2, 1);
		write_line(2, 1);
		read_line(2, 1);
		check_count("pmem_read count", 1, pmem_reads - reads_start);
		check_count("pmem_write count", 0, pmem_writes - writes_start);
		finish_test(2, "write hit then read");

		// A, B, A leaves B least recent, so C replaces B
		read_line(1, 2);
		read_line(2, 2);
		read_line(1, 2);
		read_line(3, 2);
		snapshot_traffic();
		read_line(1, 2);
		check_count("pmem_read count", 0, pmem_reads - reads_start);
		finish_test(3, "lru order");

		write_line(0, 5);
		read_line(1, 5);
		snapshot_traffic();
		read_line(2, 5);
		check_count("pmem_write count", 1, pmem_writes - writes_start);
		assert (last_wb_addr == line_addr(0, 5)) else begin
			$display("Error at %0t ns: pmem_address expected %h got %h",
				$time, line_addr(0, 5), last_wb_addr);
			stim_errors++;
		end
		assert (last_wb_data == shadow_mem[line_slot(line_addr(0, 5))]) else begin
			$display("Error at %0t ns: pmem_wdata expected %h got %h",
				$time, shadow_mem[line_slot(line_addr(0, 5))], last_wb_data);
			stim_errors++;
		end
		snapshot_traffic();
		read_line(3, 5);
		check_count("pmem_write count", 0, pmem_writes - writes_start);
		finish_test(4, "dirty eviction");

		for (int i = 0; i < 200; i++) begin
			tag = 4 + $urandom_range(3, 0);
			set = $urandom_range(7, 0);
			if ($urandom_range(1, 0) == 1) begin
				write_line(tag, set);
			end else begin
				read_line(tag, set);
			end
		end
		for (int s = 0; s < 64; s++) begin
			if (touched[s]) begin
				read_line(s >> 3, s & 7);
			end
		end
		finish_test(5, "random mix");

		$display("summary: 5 tests, %0d failed, %0d data checks, %0d errors",
			tests_failed, data_checks, total_errors());
		if (total_errors() == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- cache_system.f
+incdir+tb
hw/cache_pkg.sv
hw/line_array.sv
hw/meta_array.sv
hw/cache_datapath.sv
hw/cache_control.sv
hw/cache.sv
tb/cache_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = cache_tb
FILELIST = cache_system.f
OBJ_DIR = obj_dir
PASS_MSG = PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
